//--- rtl/core_pkg.sv
// Core-side types for the communication unit
// Addresses, data words, cache lines, MHQ tags and load/store functions

package core_pkg;

    typedef logic [31:0]  addr_t;
    typedef logic [31:0]  data_t;
    typedef logic [127:0] line_t;

    localparam int line_bytes = 16;
    localparam int mhq_depth  = 4;

    typedef logic [1:0] mhq_tag_t;

    typedef enum logic [2:0] {
        lb = 3'b000,
        lh = 3'b001,
        lw = 3'b010,
        sb = 3'b100,
        sh = 3'b101,
        sw = 3'b110
    } lsu_func_t;

    // Lookup from the load/store unit
    typedef struct packed {
        addr_t     addr;
        lsu_func_t func;
        data_t     data;
        logic      dc_hit;
    } mhq_lookup_t;

    // Line fill back to the data cache with a line-aligned addr
    typedef struct packed {
        mhq_tag_t tag;
        logic     dirty;
        addr_t    addr;
        line_t    data;
    } mhq_fill_t;

endpackage

//--- rtl/wb_pkg.sv
// Wishbone bus types
// Pipelined Wishbone master and slave bundles, beats per cache line

package wb_pkg;

    typedef logic [31:0] wb_addr_t;
    typedef logic [31:0] wb_data_t;
    typedef logic [3:0]  wb_sel_t;

    localparam int wb_beats = 4;

    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_sel_t  sel;
        wb_addr_t addr;
        wb_data_t data;
    } wb_master_t;

    typedef struct packed {
        logic     ack;
        logic     stall;
        wb_data_t data;
    } wb_slave_t;

endpackage

//--- rtl/mhq.sv
// Miss handling queue
// Allocates and merges cache misses, collects store bytes per line
// and builds the fill line once the bus fetch returns

`timescale 1ns/1ps

module mhq (
    input  logic                  clk,
    input  logic                  n_rst,
    input  logic                  i_lookup_valid,
    input  core_pkg::mhq_lookup_t i_lookup,
    input  logic                  i_ccu_done,
    input  core_pkg::line_t       i_ccu_data,
    output logic                  o_lookup_retry,
    output core_pkg::mhq_tag_t    o_lookup_tag,
    output logic                  o_fill_en,
    output core_pkg::mhq_fill_t   o_fill,
    output logic                  o_ccu_en,
    output core_pkg::addr_t       o_ccu_addr
);

    logic [core_pkg::mhq_depth-1:0]  valid_q;
    core_pkg::addr_t                 entry_addr [core_pkg::mhq_depth];
    logic                            dirty_q    [core_pkg::mhq_depth];
    logic [core_pkg::line_bytes-1:0] mask_q     [core_pkg::mhq_depth];
    core_pkg::line_t                 buf_q      [core_pkg::mhq_depth];
    core_pkg::mhq_tag_t              head_q;
    core_pkg::mhq_tag_t              tail_q;

    core_pkg::addr_t                 lookup_line;
    logic [3:0]                      word_be;
    core_pkg::data_t                 word_data;
    logic                            is_store;
    logic [core_pkg::line_bytes-1:0] store_mask;
    core_pkg::line_t                 store_line;
    logic                            match_any;
    core_pkg::mhq_tag_t              match_tag;
    logic                            full;
    logic                            active;
    logic                            alloc;
    logic                            merge;
    core_pkg::mhq_tag_t              wr_tag;
    core_pkg::line_t                 fill_line;

    assign lookup_line = {i_lookup.addr[31:4], 4'b0000};

    // Byte lanes and replicated data of a store
    always_comb begin
        case (i_lookup.func)
            core_pkg::sb: begin
                word_be   = 4'b0001 << i_lookup.addr[1:0];
                word_data = {4{i_lookup.data[7:0]}};
            end
            core_pkg::sh: begin
                word_be   = 4'b0011 << {i_lookup.addr[1], 1'b0};
                word_data = {2{i_lookup.data[15:0]}};
            end
            core_pkg::sw: begin
                word_be   = 4'b1111;
                word_data = i_lookup.data;
            end
            default: begin
                word_be   = 4'b0000;
                word_data = i_lookup.data;
            end
        endcase
    end

    assign is_store   = |word_be;
    assign store_mask = {{(core_pkg::line_bytes-4){1'b0}}, word_be} << {i_lookup.addr[3:2], 2'b00};
    assign store_line = {4{word_data}};

    // Line address match against every live entry
    always_comb begin
        match_any = 1'b0;
        match_tag = '0;
        for (int i = core_pkg::mhq_depth - 1; i >= 0; i--) begin
            if (valid_q[i] && entry_addr[i] == lookup_line) begin
                match_any = 1'b1;
                match_tag = core_pkg::mhq_tag_t'(i);
            end
        end
    end

    assign full   = valid_q[tail_q];
    assign active = i_lookup_valid & ~i_lookup.dc_hit;

    // Head bytes are being sampled for the fill this cycle, so a merge there must wait
    assign o_lookup_retry = active & (match_any ? (i_ccu_done & (match_tag == head_q)) : full);
    assign o_lookup_tag   = match_any ? match_tag : tail_q;

    assign alloc  = active & ~o_lookup_retry & ~match_any;
    assign merge  = active & ~o_lookup_retry & match_any;
    assign wr_tag = match_any ? match_tag : tail_q;

    // Stored bytes override the fetched line
    always_comb begin
        for (int b = 0; b < core_pkg::line_bytes; b++) begin
            fill_line[b*8 +: 8] = mask_q[head_q][b] ? buf_q[head_q][b*8 +: 8]
                                                    : i_ccu_data[b*8 +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (~n_rst) begin
            valid_q   <= '0;
            head_q    <= '0;
            tail_q    <= '0;
            o_fill_en <= 1'b0;
        end else begin
            o_fill_en <= i_ccu_done;
            if (alloc) begin
                valid_q[tail_q] <= 1'b1;
                tail_q          <= tail_q + 1'b1;
            end
            if (i_ccu_done) begin
                valid_q[head_q] <= 1'b0;
                head_q          <= head_q + 1'b1;
            end
        end
    end

    // Entry payload and fill register
    always_ff @(posedge clk) begin
        if (alloc) begin
            entry_addr[tail_q] <= lookup_line;
            dirty_q[tail_q]    <= is_store;
            mask_q[tail_q]     <= store_mask;
        end else if (merge) begin
            dirty_q[match_tag] <= dirty_q[match_tag] | is_store;
            mask_q[match_tag]  <= mask_q[match_tag] | store_mask;
        end
        if (alloc || merge) begin
            for (int b = 0; b < core_pkg::line_bytes; b++) begin
                if (store_mask[b]) begin
                    buf_q[wr_tag][b*8 +: 8] <= store_line[b*8 +: 8];
                end
            end
        end
        if (i_ccu_done) begin
            o_fill.tag   <= head_q;
            o_fill.dirty <= dirty_q[head_q];
            o_fill.addr  <= entry_addr[head_q];
            o_fill.data  <= fill_line;
        end
    end

    assign o_ccu_en   = valid_q[head_q];
    assign o_ccu_addr = entry_addr[head_q];

endmodule

//--- rtl/wb_biu.sv
// Wishbone bus interface unit
// Reads one cache line as four pipelined single reads

`timescale 1ns/1ps

module wb_biu (
    input  logic                clk,
    input  logic                n_rst,
    input  logic                i_biu_en,
    input  core_pkg::addr_t     i_biu_addr,
    input  wb_pkg::wb_slave_t   i_wb,
    output wb_pkg::wb_master_t  o_wb,
    output core_pkg::line_t     o_biu_data,
    output logic                o_biu_busy,
    output logic                o_biu_done
);

    logic                                  cyc_q;
    logic                                  stb_q;
    logic                                  done_q;
    logic [$clog2(wb_pkg::wb_beats)-1:0]   issue_cnt;
    logic [$clog2(wb_pkg::wb_beats)-1:0]   ack_cnt;
    wb_pkg::wb_addr_t                      addr_q;
    core_pkg::line_t                       line_q;
    logic                                  start;
    logic                                  accept;
    logic                                  ack;

    // Idle also excludes the done cycle so the enable level cannot reopen the bus
    assign start  = i_biu_en & ~cyc_q & ~done_q;
    assign accept = cyc_q & stb_q & ~i_wb.stall;
    assign ack    = cyc_q & i_wb.ack;

    always_ff @(posedge clk) begin
        if (~n_rst) begin
            cyc_q     <= 1'b0;
            stb_q     <= 1'b0;
            done_q    <= 1'b0;
            issue_cnt <= '0;
            ack_cnt   <= '0;
        end else begin
            done_q <= 1'b0;
            if (start) begin
                cyc_q     <= 1'b1;
                stb_q     <= 1'b1;
                issue_cnt <= '0;
                ack_cnt   <= '0;
            end else begin
                if (accept) begin
                    issue_cnt <= issue_cnt + 1'b1;
                    if (issue_cnt == wb_pkg::wb_beats - 1) begin
                        stb_q <= 1'b0;
                    end
                end
                if (ack) begin
                    ack_cnt <= ack_cnt + 1'b1;
                    if (ack_cnt == wb_pkg::wb_beats - 1) begin
                        cyc_q  <= 1'b0;
                        done_q <= 1'b1;
                    end
                end
            end
        end
    end

    // Address walk and line assembly with the oldest word lowest
    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= {i_biu_addr[31:4], 4'b0000};
        end else if (accept) begin
            addr_q <= addr_q + 32'd4;
        end
        if (ack) begin
            line_q <= {i_wb.data,
                       line_q[$bits(core_pkg::line_t)-1:$bits(wb_pkg::wb_data_t)]};
        end
    end

    always_comb begin
        o_wb.cyc  = cyc_q;
        o_wb.stb  = stb_q;
        o_wb.we   = 1'b0;
        o_wb.sel  = '1;
        o_wb.addr = addr_q;
        o_wb.data = '0;
    end

    assign o_biu_data = line_q;
    assign o_biu_busy = cyc_q;
    assign o_biu_done = done_q;

endmodule

//--- rtl/ccu.sv
// Core communication unit
// Sequences MHQ line fetches onto the Wishbone bus unit

`timescale 1ns/1ps

module ccu (
    input  logic                  clk,
    input  logic                  n_rst,
    input  logic                  i_lookup_valid,
    input  core_pkg::mhq_lookup_t i_lookup,
    input  wb_pkg::wb_slave_t     i_wb,
    output logic                  o_lookup_retry,
    output core_pkg::mhq_tag_t    o_lookup_tag,
    output logic                  o_fill_en,
    output core_pkg::mhq_fill_t   o_fill,
    output wb_pkg::wb_master_t    o_wb
);

    typedef enum logic [1:0] {
        st_idle = 2'b00,
        st_req  = 2'b01,
        st_wait = 2'b10,
        st_done = 2'b11
    } state_t;

    state_t           state_q;
    state_t           state_d;
    logic             ccu_en;
    logic             ccu_done;
    core_pkg::addr_t  ccu_addr;
    logic             biu_en;
    logic             biu_busy;
    logic             biu_done;
    core_pkg::line_t  biu_data;

    assign biu_en   = (state_q == st_req) | (state_q == st_wait);
    assign ccu_done = state_q == st_done;

    always_comb begin
        case (state_q)
            st_idle: state_d = (ccu_en & ~biu_busy) ? st_req : st_idle;
            st_req:  state_d = st_wait;
            st_wait: state_d = biu_done ? st_done : st_wait;
            default: state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (~n_rst) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    mhq u_mhq (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_lookup_valid (i_lookup_valid),
        .i_lookup       (i_lookup),
        .i_ccu_done     (ccu_done),
        .i_ccu_data     (biu_data),
        .o_lookup_retry (o_lookup_retry),
        .o_lookup_tag   (o_lookup_tag),
        .o_fill_en      (o_fill_en),
        .o_fill         (o_fill),
        .o_ccu_en       (ccu_en),
        .o_ccu_addr     (ccu_addr)
    );

    wb_biu u_biu (
        .clk        (clk),
        .n_rst      (n_rst),
        .i_biu_en   (biu_en),
        .i_biu_addr (ccu_addr),
        .i_wb       (i_wb),
        .o_wb       (o_wb),
        .o_biu_data (biu_data),
        .o_biu_busy (biu_busy),
        .o_biu_done (biu_done)
    );

endmodule

//--- testbench/ccu_checker.sv
// Result checker for the communication unit
// Mirrors the miss queue, predicts lookup answers, fill lines and bus beats

`timescale 1ns/1ps

module ccu_checker (
    input  logic                  clk,
    input  logic                  n_rst,
    input  logic                  i_lookup_valid,
    input  core_pkg::mhq_lookup_t i_lookup,
    input  logic                  i_lookup_retry,
    input  core_pkg::mhq_tag_t    i_lookup_tag,
    input  logic                  i_fill_en,
    input  core_pkg::mhq_fill_t   i_fill,
    input  wb_pkg::wb_master_t    i_wb_m,
    input  wb_pkg::wb_slave_t     i_wb_s,
    input  int                    i_test,
    input  logic                  i_last,
    input  logic                  i_exp_retry,
    input  core_pkg::mhq_tag_t    i_exp_tag,
    output int                    o_tests_done,
    output int                    o_checks,
    output int                    o_errors,
    output int                    o_pending
);

    typedef struct {
        core_pkg::mhq_tag_t              tag;
        core_pkg::addr_t                 addr;
        logic                            dirty;
        logic [core_pkg::line_bytes-1:0] mask;
        core_pkg::line_t                 data;
        int                              test;
    } entry_t;

    localparam int max_tests = 16;

    entry_t                q[$];
    core_pkg::mhq_tag_t    next_tag;
    int                    beats;
    int                    tests_done;
    int                    checks;
    int                    errors;
    int                    pend_fills [max_tests];
    int                    n_lookups  [max_tests];
    int                    n_fills    [max_tests];
    int                    test_errs  [max_tests];
    bit                    closed     [max_tests];
    bit                    reported   [max_tests];

    logic                  prev_valid;
    core_pkg::mhq_lookup_t prev_lk;
    logic                  prev_retry;
    core_pkg::mhq_tag_t    prev_tag;
    int                    prev_test;
    logic                  prev_last;
    logic                  prev_exp_retry;
    core_pkg::mhq_tag_t    prev_exp_tag;

    task automatic flag_error(input int t, input string msg);
        errors++;
        test_errs[t]++;
        $display("error at %0d ns: %s", $time, msg);
    endtask

    task automatic close_test(input int t);
        if (closed[t] && pend_fills[t] == 0 && !reported[t]) begin
            reported[t] = 1'b1;
            tests_done++;
            $display("test %0d: %0d lookups, %0d fills, %0d errors",
                     t, n_lookups[t], n_fills[t], test_errs[t]);
        end
    endtask

    // Store bytes land little endian at the address offset
    function automatic entry_t merge_store(input entry_t e, input core_pkg::mhq_lookup_t lk);
        int n;
        int off;
        case (lk.func)
            core_pkg::sb: begin
                n   = 1;
                off = int'(lk.addr[3:0]);
            end
            core_pkg::sh: begin
                n   = 2;
                off = int'({lk.addr[3:1], 1'b0});
            end
            core_pkg::sw: begin
                n   = 4;
                off = int'({lk.addr[3:2], 2'b00});
            end
            default: begin
                n   = 0;
                off = 0;
            end
        endcase
        for (int i = 0; i < n; i++) begin
            e.data[(off + i) * 8 +: 8] = lk.data[i * 8 +: 8];
            e.mask[off + i]            = 1'b1;
            e.dirty                    = 1'b1;
        end
        return e;
    endfunction

    function automatic core_pkg::line_t expected_line(input entry_t e);
        core_pkg::line_t line;
        for (int w = 0; w < wb_pkg::wb_beats; w++) begin
            line[w * 32 +: 32] = (e.addr + 32'(w * 4)) ^ 32'h5a5a0000;
        end
        for (int b = 0; b < core_pkg::line_bytes; b++) begin
            if (e.mask[b]) line[b * 8 +: 8] = e.data[b * 8 +: 8];
        end
        return line;
    endfunction

    // A merge into the head is refused in the cycle the head retires
    task automatic resolve_lookup(input logic done);
        core_pkg::addr_t    line;
        int                 idx;
        logic               exp_retry;
        core_pkg::mhq_tag_t exp_tag;
        entry_t             e;
        line = {prev_lk.addr[31:4], 4'b0000};
        idx  = -1;
        foreach (q[i]) begin
            if (q[i].addr == line) idx = i;
        end
        n_lookups[prev_test]++;
        if (prev_lk.dc_hit) exp_retry = 1'b0;
        else if (idx >= 0) exp_retry = done && (idx == 0);
        else exp_retry = (q.size() == core_pkg::mhq_depth);
        exp_tag = (idx >= 0) ? q[idx].tag : next_tag;
        checks++;
        if (prev_retry !== exp_retry || prev_retry !== prev_exp_retry)
            flag_error(prev_test, $sformatf("lookup %h retry %b, model %b, vector %b",
                       prev_lk.addr, prev_retry, exp_retry, prev_exp_retry));
        if (!prev_lk.dc_hit && !exp_retry) begin
            if (prev_tag !== exp_tag || prev_tag !== prev_exp_tag)
                flag_error(prev_test, $sformatf("lookup %h tag %0d, model %0d, vector %0d",
                           prev_lk.addr, prev_tag, exp_tag, prev_exp_tag));
            if (idx < 0) begin
                e.tag   = next_tag;
                e.addr  = line;
                e.dirty = 1'b0;
                e.mask  = '0;
                e.data  = '0;
                e.test  = prev_test;
                next_tag = next_tag + 1'b1;
                pend_fills[prev_test]++;
                q.push_back(e);
                idx = q.size() - 1;
            end
            q[idx] = merge_store(q[idx], prev_lk);
        end
        if (prev_last) closed[prev_test] = 1'b1;
        close_test(prev_test);
    endtask

    task automatic check_fill();
        entry_t          e;
        core_pkg::line_t exp_line;
        if (q.size() == 0) begin
            $display("fill with tag %0d arrived while no miss was outstanding", i_fill.tag);
            errors++;
        end else begin
            e        = q.pop_front();
            exp_line = expected_line(e);
            checks++;
            if (i_fill.tag !== e.tag || i_fill.dirty !== e.dirty || i_fill.addr !== e.addr)
                flag_error(e.test, $sformatf("fill tag %0d dirty %b addr %h, expected %0d %b %h",
                           i_fill.tag, i_fill.dirty, i_fill.addr, e.tag, e.dirty, e.addr));
            if (i_fill.data !== exp_line)
                flag_error(e.test, $sformatf("fill data %h, expected %h", i_fill.data, exp_line));
            if (beats != wb_pkg::wb_beats)
                flag_error(e.test, $sformatf("%0d bus beats for line %h", beats, e.addr));
            beats = 0;
            n_fills[e.test]++;
            pend_fills[e.test]--;
            close_test(e.test);
        end
    endtask

    task automatic check_strobe();
        core_pkg::addr_t exp_addr;
        if (i_wb_m.cyc && i_wb_m.stb && !i_wb_s.stall) begin
            if (q.size() == 0) begin
                $display("bus strobe at %h with no outstanding miss", i_wb_m.addr);
                errors++;
            end else begin
                exp_addr = q[0].addr + 32'(beats * 4);
                checks++;
                if (beats >= wb_pkg::wb_beats || i_wb_m.addr !== exp_addr ||
                    i_wb_m.we !== 1'b0 || i_wb_m.sel !== 4'hf)
                    flag_error(q[0].test, $sformatf("beat %0d addr %h we %b sel %h, expected %h",
                               beats, i_wb_m.addr, i_wb_m.we, i_wb_m.sel, exp_addr));
                beats++;
            end
        end
    endtask

    // Lookup answers are judged a cycle late when the fill pulse shows a retire
    always @(posedge clk) begin
        if (!n_rst) begin
            prev_valid = 1'b0;
            next_tag   = '0;
            beats      = 0;
            q.delete();
        end else begin
            if (prev_valid) resolve_lookup(i_fill_en);
            if (i_fill_en) check_fill();
            check_strobe();
            prev_valid     = i_lookup_valid;
            prev_lk        = i_lookup;
            prev_retry     = i_lookup_retry;
            prev_tag       = i_lookup_tag;
            prev_test      = i_test;
            prev_last      = i_last;
            prev_exp_retry = i_exp_retry;
            prev_exp_tag   = i_exp_tag;
        end
        o_tests_done <= tests_done;
        o_checks     <= checks;
        o_errors     <= errors;
        o_pending    <= q.size();
    end

endmodule

//--- testbench/ccu_tb.sv
// Testbench top for the communication unit
// Drives lookups from a vector file against a Wishbone memory model

`timescale 1ns/1ps

module ccu_tb;

    logic                  clk = 1'b0;
    logic                  n_rst;
    logic                  lookup_valid;
    core_pkg::mhq_lookup_t lookup;
    wb_pkg::wb_slave_t     wb_s;
    logic                  lookup_retry;
    core_pkg::mhq_tag_t    lookup_tag;
    logic                  fill_en;
    core_pkg::mhq_fill_t   fill;
    wb_pkg::wb_master_t    wb_m;

    int                    cur_test;
    logic                  cur_last;
    logic                  exp_retry;
    core_pkg::mhq_tag_t    exp_tag;
    int                    tests_done;
    int                    checks;
    int                    errors;
    int                    pending;

    int                    vec_test  [$];
    logic [31:0]           vec_addr  [$];
    logic [2:0]            vec_func  [$];
    logic                  vec_hit   [$];
    logic [31:0]           vec_data  [$];
    logic                  vec_retry [$];
    int                    vec_tag   [$];
    bit                    vec_loaded = 1'b0;

    logic [31:0]           rnd = 32'hcaf9a1c2;
    int                    cycle_cnt = 0;
    logic [31:0]           rd_addr  [$];
    int                    rd_ready [$];

    always #4 clk = ~clk;

    ccu u_dut (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_lookup_valid (lookup_valid),
        .i_lookup       (lookup),
        .i_wb           (wb_s),
        .o_lookup_retry (lookup_retry),
        .o_lookup_tag   (lookup_tag),
        .o_fill_en      (fill_en),
        .o_fill         (fill),
        .o_wb           (wb_m)
    );

    ccu_checker u_check (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_lookup_valid (lookup_valid),
        .i_lookup       (lookup),
        .i_lookup_retry (lookup_retry),
        .i_lookup_tag   (lookup_tag),
        .i_fill_en      (fill_en),
        .i_fill         (fill),
        .i_wb_m         (wb_m),
        .i_wb_s         (wb_s),
        .i_test         (cur_test),
        .i_last         (cur_last),
        .i_exp_retry    (exp_retry),
        .i_exp_tag      (exp_tag),
        .o_tests_done   (tests_done),
        .o_checks       (checks),
        .o_errors       (errors),
        .o_pending      (pending)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Memory model returning address xor 5a5a0000 with acks in issue order
    always begin
        @(posedge clk);
        cycle_cnt++;
        if (n_rst && wb_m.cyc && wb_m.stb && !wb_s.stall) begin
            rnd = lcg_next(rnd);
            rd_addr.push_back(wb_m.addr);
            rd_ready.push_back(cycle_cnt + int'(rnd[29:28]));
        end
        #1;
        rnd = lcg_next(rnd);
        wb_s.stall = (rnd[31:30] == 2'b00);
        if (rd_addr.size() > 0 && rd_ready[0] <= cycle_cnt) begin
            wb_s.ack  = 1'b1;
            wb_s.data = rd_addr.pop_front() ^ 32'h5a5a0000;
            void'(rd_ready.pop_front());
        end else begin
            wb_s.ack  = 1'b0;
            wb_s.data = '0;
        end
    end

    task automatic load_vectors(output bit ok);
        int          fd;
        int          n;
        string       text;
        int          t;
        logic [31:0] a;
        logic [31:0] d;
        int          f;
        int          h;
        int          r;
        int          g;
        fd = $fopen("testbench/ccu_vectors.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd)) begin
                text = "";
                n = $fgets(text, fd);
                if (text.len() > 1 && text[0] != "#") begin
                    n = $sscanf(text, "%d %h %d %d %h %d %d", t, a, f, h, d, r, g);
                    if (n == 7) begin
                        vec_test.push_back(t);
                        vec_addr.push_back(a);
                        vec_func.push_back(f[2:0]);
                        vec_hit.push_back(h[0]);
                        vec_data.push_back(d);
                        vec_retry.push_back(r[0]);
                        vec_tag.push_back(g);
                    end
                end
            end
            $fclose(fd);
            ok = (vec_test.size() > 0);
        end
    endtask

    task automatic drive_lookup(input int i, input logic last);
        @(posedge clk);
        #1;
        lookup_valid  = 1'b1;
        lookup.addr   = vec_addr[i];
        lookup.func   = core_pkg::lsu_func_t'(vec_func[i]);
        lookup.data   = vec_data[i];
        lookup.dc_hit = vec_hit[i];
        cur_test      = vec_test[i];
        cur_last      = last;
        exp_retry     = vec_retry[i];
        exp_tag       = core_pkg::mhq_tag_t'(vec_tag[i]);
    endtask

    initial begin
        bit ok;
        int i;
        int t;
        int groups;
        n_rst        = 1'b0;
        lookup_valid = 1'b0;
        lookup       = '0;
        wb_s         = '0;
        cur_test     = 0;
        cur_last     = 1'b0;
        exp_retry    = 1'b0;
        exp_tag      = '0;
        groups       = 0;
        load_vectors(ok);
        if (!ok) begin
            $display("could not read any vectors from testbench/ccu_vectors.txt");
            $display(">>> FAIL");
            $finish;
        end else begin
            vec_loaded = 1'b1;
            repeat (16) @(posedge clk);
            #1;
            n_rst = 1'b1;
            i = 0;
            while (i < vec_test.size()) begin
                t = vec_test[i];
                while (i < vec_test.size() && vec_test[i] == t) begin
                    drive_lookup(i, (i + 1 == vec_test.size()) || (vec_test[i + 1] != t));
                    i++;
                end
                @(posedge clk);
                #1;
                lookup_valid = 1'b0;
                cur_last     = 1'b0;
                groups++;
                // Group is closed once all its fills are in
                while (tests_done < groups) @(posedge clk);
                repeat (4) @(posedge clk);
            end
            repeat (8) @(posedge clk);
            if (pending != 0) $display("%0d fills never arrived", pending);
            $display("tests %0d of %0d, checks %0d, errors %0d",
                     tests_done, groups, checks, errors);
            if (errors == 0 && pending == 0 && tests_done == groups) begin
                $display(">>> PASS");
            end else begin
                $display(">>> FAIL");
            end
            $finish;
        end
    end

    // Watchdog scaled by the vector count
    initial begin
        wait (vec_loaded);
        repeat (vec_test.size() * 200) @(posedge clk);
        $display("timeout after %0d cycles, test %0d still waiting for its fills",
                 vec_test.size() * 200, cur_test);
        $display(">>> FAIL");
        $finish;
    end

endmodule

//--- testbench/ccu_vectors.txt
# test addr func dc_hit data exp_retry exp_tag
# func 0 lb, 1 lh, 2 lw, 4 sb, 5 sh, 6 sw; tag is ignored on dc_hit or retry
1 00001004 2 0 00000000 0 0
2 00002003 4 0 000000a5 0 1
2 00003006 5 0 0000beef 0 2
2 0000400c 6 0 12345678 0 3
2 00004001 4 0 00000077 0 3
3 00005000 0 0 00000000 0 0
3 00005008 1 0 00000000 0 0
3 0000500f 4 0 0000003c 0 0
3 00006000 2 1 00000000 0 0
4 00007000 2 0 00000000 0 1
4 00007010 2 0 00000000 0 2
4 00007020 6 0 a5a5f00d 0 3
4 00007030 2 0 00000000 0 0
4 00007040 2 0 00000000 1 0
5 00008000 6 0 deadbeef 0 1
5 00008012 5 0 00001234 0 2
5 00008020 0 0 00000000 0 3
5 00008011 4 0 00000099 0 2
5 00008028 6 0 cafe0001 0 3
5 00008030 1 0 00000000 0 0

//--- vlog.f
rtl/core_pkg.sv
rtl/wb_pkg.sv
rtl/mhq.sv
rtl/wb_biu.sv
rtl/ccu.sv
testbench/ccu_checker.sv
testbench/ccu_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f vlog.f --top-module ccu_tb -Mdir obj_dir
	@out="$$(./obj_dir/Vccu_tb)"; echo "$$out"; echo "$$out" | grep -qF ">>> PASS"

clean:
	rm -rf obj_dir
